// File: sources.f
+incdir+bench
hw/csr_pkg.sv
hw/csr_op_decode.sv
hw/csr_counters.sv
hw/csr_trap_unit.sv
hw/csr_regfile.sv
hw/csr_ehu_top.sv
bench/tb_csr_ehu.sv

// File: Makefile
# Verilator build and run of the CSR block testbench
VERILATOR ?= verilator
TOP       ?= tb_csr_ehu
MDIR      ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All checks passed

.PHONY: sim clean

# Output is kept in a shell variable, shown, then searched for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f sources.f
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(MDIR)

// File: bench/csr_tb_table.svh
// Stimulus table for the CSR block testbench
// Row type, row builders and the table, with expected values from a small model
typedef struct {
   string               name;
   csr_pkg::csr_req_t   req;
   csr_pkg::exc_flags_t exc;
   logic                bubble;
   csr_pkg::word_t      pc;
   csr_pkg::word_t      alu;
   csr_pkg::word_t      npc;
   logic                chk_rd;
   csr_pkg::word_t      exp_rd;
   logic                exp_trap;
} stim_row_t;

stim_row_t rows[$];

function automatic csr_pkg::csr_req_t make_req(
   input csr_pkg::csr_op_e   op,
   input logic               imm,
   input logic [4:0]         rd,
   input csr_pkg::csr_addr_t addr,
   input logic [4:0]         uimm,
   input csr_pkg::word_t     rs1
);
   csr_pkg::csr_req_t q;
   q.op       = op;
   q.imm      = imm;
   q.rd       = rd;
   q.addr     = addr;
   q.uimm     = uimm;
   q.rs1_data = rs1;
   return q;
endfunction

// PC, ALU result and next PC are random in every row
task automatic push_row(
   input string               name,
   input csr_pkg::csr_req_t   req,
   input csr_pkg::exc_flags_t e,
   input logic                bubble,
   input logic                chk,
   input csr_pkg::word_t      exp_rd,
   input logic                exp_trap
);
   stim_row_t r;
   r.name     = name;
   r.req      = req;
   r.exc      = e;
   r.bubble   = bubble;
   r.pc       = rand_bits(32) & ~32'h3;
   r.alu      = rand_bits(32);
   r.npc      = rand_bits(32);
   r.chk_rd   = chk;
   r.exp_rd   = exp_rd;
   r.exp_trap = exp_trap;
   rows.push_back(r);
endtask

task automatic csr_step(
   input string              name,
   input csr_pkg::csr_op_e   op,
   input logic               imm,
   input logic [4:0]         rd,
   input csr_pkg::csr_addr_t addr,
   input logic [4:0]         uimm,
   input csr_pkg::word_t     rs1,
   input logic               chk,
   input csr_pkg::word_t     exp_rd
);
   push_row(name, make_req(op, imm, rd, addr, uimm, rs1), 6'b0, 1'b0, chk, exp_rd, 1'b0);
endtask

// csrrs with rs1 = x0 is a pure read
task automatic read_expect(
   input string              name,
   input csr_pkg::csr_addr_t addr,
   input csr_pkg::word_t     exp_rd
);
   csr_step(name, csr_pkg::OP_RS, 1'b0, 5'd1, addr, 5'd0, 32'd0, 1'b1, exp_rd);
endtask

task automatic idle_cycle(
   input string               name,
   input csr_pkg::exc_flags_t e,
   input logic                bubble,
   input logic                exp_trap
);
   push_row(name, make_req(csr_pkg::OP_NONE, 1'b0, 5'd0, 12'h000, 5'd0, 32'd0),
            e, bubble, 1'b0, 32'd0, exp_trap);
endtask

// Trap cycle, then reads of mepc, mcause and mtval
task automatic trap_case(
   input string               name,
   input csr_pkg::exc_flags_t e,
   input logic [3:0]          cause,
   input csr_pkg::word_t      tval
);
   csr_pkg::word_t pc;
   idle_cycle(name, e, 1'b0, 1'b1);
   pc = rows[$].pc;
   read_expect({name, " mepc"}, csr_pkg::CSR_MEPC, pc);
   read_expect({name, " mcause"}, csr_pkg::CSR_MCAUSE, {28'd0, cause});
   read_expect({name, " mtval"}, csr_pkg::CSR_MTVAL, tval);
endtask

// Flag bit order: unsupported, illegal, ecall, inst, load, store misaligned
task automatic build_table();
   csr_pkg::word_t   scr;
   csr_pkg::word_t   val;
   csr_pkg::word_t   opnd;
   csr_pkg::word_t   cyc;
   csr_pkg::word_t   ins;
   csr_pkg::csr_op_e op;
   logic             imm;
   logic             bub;
   logic [4:0]       uimm;
   int               nb;
   int               iw;
   int               i;
   read_expect("mvendorid", csr_pkg::CSR_MVENDORID, 32'd0);
   read_expect("marchid", csr_pkg::CSR_MARCHID, 32'd0);
   read_expect("mimpid", csr_pkg::CSR_MIMPID, 32'd0);
   read_expect("mhartid", csr_pkg::CSR_MHARTID, 32'd0);
   // MXL of 1 in bits 31:30, I extension in bit 8
   read_expect("misa", csr_pkg::CSR_MISA, 32'h4000_0100);
   csr_step("read with rd x0", csr_pkg::OP_RS, 1'b0, 5'd0, csr_pkg::CSR_MHARTID, 5'd0,
            32'd0, 1'b1, 32'h4000_0100);
   read_expect("mhpmcounter5", 12'hB05, 32'd0);
   read_expect("mhpmevent3", 12'h323, 32'd0);

   // mscratch against replace, OR and AND-NOT
   scr = rand_bits(32);
   csr_step("mscratch init", csr_pkg::OP_RW, 1'b0, 5'd0, csr_pkg::CSR_MSCRATCH, 5'd5,
            scr, 1'b0, 32'd0);
   for (i = 0; i < 9; i++) begin
      case (i % 3)
         0:       op = csr_pkg::OP_RW;
         1:       op = csr_pkg::OP_RS;
         default: op = csr_pkg::OP_RC;
      endcase
      imm  = 1'(rand_bits(1));
      uimm = imm ? 5'(rand_bits(5)) : 5'd5;
      val  = rand_bits(32);
      opnd = imm ? {27'd0, uimm} : val;
      csr_step($sformatf("mscratch op %0d", i), op, imm, 5'd1, csr_pkg::CSR_MSCRATCH,
               uimm, val, 1'b1, scr);
      if (op == csr_pkg::OP_RW) begin
         scr = opnd;
      end else if (uimm != 5'd0 && op == csr_pkg::OP_RS) begin
         scr = scr | opnd;
      end else if (uimm != 5'd0) begin
         scr = scr & ~opnd;
      end
   end
   val = rand_bits(32);
   csr_step("mscratch set x0", csr_pkg::OP_RS, 1'b0, 5'd1, csr_pkg::CSR_MSCRATCH, 5'd0,
            val, 1'b1, scr);
   csr_step("mscratch clear uimm 0", csr_pkg::OP_RC, 1'b1, 5'd1, csr_pkg::CSR_MSCRATCH,
            5'd0, val, 1'b1, scr);
   read_expect("mscratch final", csr_pkg::CSR_MSCRATCH, scr);

   // MPP reads as 3, MIE bit 3, MPIE bit 7
   read_expect("mstatus reset", csr_pkg::CSR_MSTATUS, 32'h0000_1800);
   csr_step("mstatus set mie", csr_pkg::OP_RS, 1'b1, 5'd1, csr_pkg::CSR_MSTATUS, 5'd8,
            32'd0, 1'b1, 32'h0000_1800);
   read_expect("mstatus mie", csr_pkg::CSR_MSTATUS, 32'h0000_1808);
   trap_case("load misaligned", 6'b000010, 4'd4, rows[$].alu);
   read_expect("mstatus mpie", csr_pkg::CSR_MSTATUS, 32'h0000_1888);
   read_expect("mtvec reset", csr_pkg::CSR_MTVEC, 32'h0000_0004);
   val = rand_bits(32);
   csr_step("mtvec write", csr_pkg::OP_RW, 1'b0, 5'd0, csr_pkg::CSR_MTVEC, 5'd5, val,
            1'b0, 32'd0);
   read_expect("mtvec readback", csr_pkg::CSR_MTVEC, val & ~32'h3);

   // FD flags and their priority
   trap_case("inst misaligned", 6'b000100, 4'd0, rows[$].npc);
   trap_case("illegal", 6'b010000, 4'd2, 32'd0);
   trap_case("unsupported", 6'b100000, 4'd2, 32'd0);
   trap_case("illegal with ecall", 6'b011000, 4'd11, 32'd0);
   trap_case("store misaligned", 6'b000001, 4'd6, rows[$].alu);
   trap_case("inst before store", 6'b000101, 4'd0, rows[$].npc);
   trap_case("illegal before load", 6'b010010, 4'd2, 32'd0);
   idle_cycle("ecall alone", 6'b001000, 1'b0, 1'b0);
   idle_cycle("load in bubble", 6'b000010, 1'b1, 1'b0);

   // Unknown CSR traps one cycle later
   csr_step("unknown csr", csr_pkg::OP_RS, 1'b0, 5'd1, 12'h7C0, 5'd0, 32'd0, 1'b0, 32'd0);
   trap_case("unknown csr trap", 6'b000000, 4'd2, 32'd0);
   csr_step("unknown csr again", csr_pkg::OP_RS, 1'b0, 5'd1, 12'h7C0, 5'd0, 32'd0,
            1'b0, 32'd0);
   idle_cycle("bubble after unknown", 6'b000000, 1'b1, 1'b0);
   idle_cycle("no late trap", 6'b000000, 1'b0, 1'b0);

   // Counters over a random bubble pattern
   cyc = rand_bits(32);
   ins = rand_bits(32);
   iw  = rows.size();
   csr_step("mcycle write", csr_pkg::OP_RW, 1'b0, 5'd0, csr_pkg::CSR_MCYCLE, 5'd5, cyc,
            1'b0, 32'd0);
   csr_step("minstret write", csr_pkg::OP_RW, 1'b0, 5'd0, csr_pkg::CSR_MINSTRET, 5'd5,
            ins, 1'b0, 32'd0);
   nb = 0;
   for (i = 0; i < 16; i++) begin
      bub = 1'(rand_bits(1));
      idle_cycle($sformatf("counter run %0d", i), 6'b000000, bub, 1'b0);
      if (!bub) begin
         nb++;
      end
   end
   read_expect("minstret delta", csr_pkg::CSR_MINSTRET, ins + nb);
   read_expect("mcycle delta", csr_pkg::CSR_MCYCLE, cyc + rows.size() - iw - 1);
endtask

// File: bench/tb_csr_ehu.sv
// Testbench for the CSR block and exception handling unit
// Applies the stimulus table one row per cycle and checks rdata and the trap level
`timescale 1ns/100ps

module tb_csr_ehu;

   logic                clk;
   logic                resetb;
   logic                xb_bubble;
   csr_pkg::csr_req_t   csr_req;
   csr_pkg::exc_flags_t exc;
   csr_pkg::word_t      xb_pc;
   csr_pkg::word_t      fd_alu_out;
   csr_pkg::word_t      next_pc;
   csr_pkg::word_t      rdata;
   csr_pkg::word_t      csr_mepc;
   csr_pkg::word_t      csr_mtvec;
   logic                initiate_exception;

   logic [31:0]         lfsr;
   logic                table_ready = 1'b0;
   int                  errors;
   int                  row_errors;

   `include "csr_tb_table.svh"

   csr_ehu_top DUT (
      .clk                (clk),
      .resetb             (resetb),
      .xb_bubble          (xb_bubble),
      .csr_req            (csr_req),
      .exc                (exc),
      .xb_pc              (xb_pc),
      .fd_alu_out         (fd_alu_out),
      .next_pc            (next_pc),
      .rdata              (rdata),
      .csr_mepc           (csr_mepc),
      .csr_mtvec          (csr_mtvec),
      .initiate_exception (initiate_exception)
   );

   // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1, one step per bit
   function automatic csr_pkg::word_t rand_bits(input int n);
      csr_pkg::word_t v;
      logic           fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   task automatic check_word(input string what, input csr_pkg::word_t exp,
                             input csr_pkg::word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %h actual %h", what, exp, act);
         errors++;
         row_errors++;
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s expected %b actual %b", what, exp, act);
         errors++;
         row_errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Ten cycles per row plus a margin
   initial begin
      wait (table_ready);
      repeat (rows.size() * 10 + 100) @(posedge clk);
      $display("Watchdog timeout: the table loop did not finish in time");
      $display("Checks failed");
      $finish;
   end

   initial begin
      resetb     = 1'b0;
      xb_bubble  = 1'b1;
      csr_req    = '0;
      exc        = '0;
      xb_pc      = '0;
      fd_alu_out = '0;
      next_pc    = '0;
      errors     = 0;
      row_errors = 0;
      lfsr       = 32'ha576c1c6;
      build_table();
      table_ready = 1'b1;
      repeat (2) @(posedge clk);
      #1;
      resetb = 1'b1;
      foreach (rows[i]) begin
         csr_req    = rows[i].req;
         exc        = rows[i].exc;
         xb_bubble  = rows[i].bubble;
         xb_pc      = rows[i].pc;
         fd_alu_out = rows[i].alu;
         next_pc    = rows[i].npc;
         row_errors = 0;
         // Trap level is combinational within the row's cycle
         #2;
         check_flag({rows[i].name, " trap"}, rows[i].exp_trap, initiate_exception);
         @(posedge clk);
         #1;
         if (rows[i].chk_rd) begin
            check_word(rows[i].name, rows[i].exp_rd, rdata);
            if (rows[i].req.addr == csr_pkg::CSR_MTVEC) begin
               check_word({rows[i].name, " csr_mtvec"}, rows[i].exp_rd, csr_mtvec);
            end
            if (rows[i].req.addr == csr_pkg::CSR_MEPC) begin
               check_word({rows[i].name, " csr_mepc"}, rows[i].exp_rd, csr_mepc);
            end
         end
         if (row_errors == 0) begin
            $display("ok       %s", rows[i].name);
         end else begin
            $display("mismatch %s", rows[i].name);
         end
      end
      $display("Rows run: %0d, errors: %0d", rows.size(), errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

// File: hw/csr_ehu_top.sv
// CSR block and exception handling unit top
// Request decode, register file, counters and trap unit
`timescale 1ns/100ps

module csr_ehu_top (
   input  logic                clk,
   input  logic                resetb,
   input  logic                xb_bubble,
   input  csr_pkg::csr_req_t   csr_req,
   input  csr_pkg::exc_flags_t exc,
   input  csr_pkg::word_t      xb_pc,
   input  csr_pkg::word_t      fd_alu_out,
   input  csr_pkg::word_t      next_pc,
   output csr_pkg::word_t      rdata,
   output csr_pkg::word_t      csr_mepc,
   output csr_pkg::word_t      csr_mtvec,
   output logic                initiate_exception
);

   csr_pkg::csr_access_t acc;
   csr_pkg::cnt_wr_t     cnt_wr;
   csr_pkg::trap_info_t  trap;
   logic [63:0]          mcycle;
   logic [63:0]          minstret;
   logic                 mie;
   logic                 csr_illegal;

   csr_op_decode u_decode (
      .clk    (clk),
      .resetb (resetb),
      .req    (csr_req),
      .acc    (acc)
   );

   csr_regfile u_regfile (
      .clk         (clk),
      .resetb      (resetb),
      .xb_bubble   (xb_bubble),
      .acc         (acc),
      .trap        (trap),
      .xb_pc       (xb_pc),
      .mcycle      (mcycle),
      .minstret    (minstret),
      .rdata       (rdata),
      .csr_mepc    (csr_mepc),
      .csr_mtvec   (csr_mtvec),
      .mie         (mie),
      .csr_illegal (csr_illegal),
      .cnt_wr      (cnt_wr)
   );

   csr_counters u_counters (
      .clk       (clk),
      .resetb    (resetb),
      .xb_bubble (xb_bubble),
      .cnt_wr    (cnt_wr),
      .mcycle    (mcycle),
      .minstret  (minstret)
   );

   csr_trap_unit u_trap (
      .clk                (clk),
      .resetb             (resetb),
      .xb_bubble          (xb_bubble),
      .csr_illegal        (csr_illegal),
      .mie                (mie),
      .exc                (exc),
      .fd_alu_out         (fd_alu_out),
      .next_pc            (next_pc),
      .initiate_exception (initiate_exception),
      .trap               (trap)
   );

endmodule

// File: hw/csr_regfile.sv
// Machine-mode CSR register file
// Holds mstatus, mtvec, mscratch and the trap registers, serves reads
// and read-modify-write, and applies the trap update
`timescale 1ns/100ps

module csr_regfile (
   input  logic                 clk,
   input  logic                 resetb,
   input  logic                 xb_bubble,
   input  csr_pkg::csr_access_t acc,
   input  csr_pkg::trap_info_t  trap,
   input  csr_pkg::word_t       xb_pc,
   input  logic [63:0]          mcycle,
   input  logic [63:0]          minstret,
   output csr_pkg::word_t       rdata,
   output csr_pkg::word_t       csr_mepc,
   output csr_pkg::word_t       csr_mtvec,
   output logic                 mie,
   output logic                 csr_illegal,
   output csr_pkg::cnt_wr_t     cnt_wr
);

   logic           mpie;
   logic [31:2]    mtvec;
   csr_pkg::word_t mscratch;
   csr_pkg::word_t mepc;
   csr_pkg::word_t mcause;
   csr_pkg::word_t mtval;
   csr_pkg::word_t cur_val;
   csr_pkg::word_t new_val;
   logic           known;
   logic           perf_hit;
   logic           modify;

   function automatic csr_pkg::word_t apply_op(
      input csr_pkg::word_t       cur,
      input csr_pkg::csr_access_t a
   );
      csr_pkg::word_t res;
      res = cur;
      if (a.wr_en) begin
         res = a.operand;
      end else if (a.set_en) begin
         res = cur | a.operand;
      end else if (a.clr_en) begin
         res = cur & ~a.operand;
      end
      return res;
   endfunction

   always_comb begin
      perf_hit = 1'b0;
      for (int i = 0; i < csr_pkg::NUM_PERF_PREFIXES; i++) begin
         if (acc.addr[11:4] == csr_pkg::PERF_PREFIXES[i]) begin
            perf_hit = 1'b1;
         end
      end
   end

   // Current value of the addressed CSR
   always_comb begin
      known   = 1'b1;
      cur_val = '0;
      case (acc.addr)
         csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID,
         csr_pkg::CSR_MIMPID, csr_pkg::CSR_MHARTID: cur_val = '0;
         // MPP fixed at machine mode
         csr_pkg::CSR_MSTATUS:   cur_val = {19'd0, 2'b11, 3'd0, mpie, 3'd0, mie, 3'd0};
         csr_pkg::CSR_MISA:      cur_val = csr_pkg::MISA_VALUE;
         csr_pkg::CSR_MTVEC:     cur_val = {mtvec, 2'b00};
         csr_pkg::CSR_MSCRATCH:  cur_val = mscratch;
         csr_pkg::CSR_MEPC:      cur_val = mepc;
         csr_pkg::CSR_MCAUSE:    cur_val = mcause;
         csr_pkg::CSR_MTVAL:     cur_val = mtval;
         csr_pkg::CSR_MCYCLE:    cur_val = mcycle[31:0];
         csr_pkg::CSR_MCYCLEH:   cur_val = mcycle[63:32];
         csr_pkg::CSR_MINSTRET:  cur_val = minstret[31:0];
         csr_pkg::CSR_MINSTRETH: cur_val = minstret[63:32];
         default:                known = perf_hit;
      endcase
   end

   assign modify  = acc.wr_en | acc.set_en | acc.clr_en;
   assign new_val = apply_op(cur_val, acc);

   // Counter halves are modified in csr_counters
   always_comb begin
      cnt_wr.cycle_lo = modify && (acc.addr == csr_pkg::CSR_MCYCLE);
      cnt_wr.cycle_hi = modify && (acc.addr == csr_pkg::CSR_MCYCLEH);
      cnt_wr.inst_lo  = modify && (acc.addr == csr_pkg::CSR_MINSTRET);
      cnt_wr.inst_hi  = modify && (acc.addr == csr_pkg::CSR_MINSTRETH);
      cnt_wr.data     = new_val;
   end

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         mie         <= 1'b0;
         mpie        <= 1'b0;
         mtvec       <= csr_pkg::MTVEC_RESET[31:2];
         csr_illegal <= 1'b0;
      end else begin
         csr_illegal <= acc.any_op && !xb_bubble && !known;
         if (modify && (acc.addr == csr_pkg::CSR_MSTATUS)) begin
            mie <= new_val[3];
         end
         if (trap.take) begin
            mpie <= mie;
         end else if (modify && (acc.addr == csr_pkg::CSR_MSTATUS)) begin
            mpie <= new_val[7];
         end
         // Direct mode only
         if (modify && (acc.addr == csr_pkg::CSR_MTVEC)) begin
            mtvec <= new_val[31:2];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (acc.rd_en) begin
         rdata <= cur_val;
      end
      if (modify && (acc.addr == csr_pkg::CSR_MSCRATCH)) begin
         mscratch <= new_val;
      end
      if (trap.take) begin
         mepc   <= xb_pc;
         mcause <= {28'd0, trap.cause};
         mtval  <= trap.tval;
      end else if (modify) begin
         case (acc.addr)
            csr_pkg::CSR_MEPC:   mepc   <= new_val;
            csr_pkg::CSR_MCAUSE: mcause <= new_val;
            csr_pkg::CSR_MTVAL:  mtval  <= new_val;
            default: ;
         endcase
      end
   end

   assign csr_mepc  = mepc;
   assign csr_mtvec = {mtvec, 2'b00};

   a_mtvec_aligned: assert property (
      @(posedge clk) disable iff (!resetb)
      csr_mtvec[1:0] == 2'b00
   ) else $error("csr_regfile: mtvec not word aligned");

endmodule

// File: hw/csr_trap_unit.sv
// Trap decision for the XB stage
// Prioritises CSR and FD exceptions and picks the cause and trap value
`timescale 1ns/100ps

module csr_trap_unit (
   input  logic                clk,
   input  logic                resetb,
   input  logic                xb_bubble,
   input  logic                csr_illegal,
   input  logic                mie,
   input  csr_pkg::exc_flags_t exc,
   input  csr_pkg::word_t      fd_alu_out,
   input  csr_pkg::word_t      next_pc,
   output logic                initiate_exception,
   output csr_pkg::trap_info_t trap
);

   csr_pkg::word_t badaddr_q;
   csr_pkg::word_t next_pc_q;
   logic           fd_exc;

   // One cycle behind, lined up with the flags now in XB
   always_ff @(posedge clk) begin
      badaddr_q <= fd_alu_out;
      next_pc_q <= next_pc;
   end

   // ecall on its own does not trap here
   assign fd_exc = exc.unsupported | exc.illegal | exc.inst_misaligned |
                   exc.load_misaligned | exc.store_misaligned;

   assign initiate_exception = !xb_bubble && (csr_illegal || fd_exc);

   always_comb begin
      trap.take  = initiate_exception;
      trap.cause = csr_pkg::CAUSE_ILLEGAL_INST;
      trap.tval  = '0;
      // CSR illegal is from the senior instruction and wins
      if (csr_illegal) begin
         trap.cause = csr_pkg::CAUSE_ILLEGAL_INST;
      end else if (exc.inst_misaligned) begin
         trap.cause = csr_pkg::CAUSE_INST_MISALIGNED;
         trap.tval  = next_pc_q;
      end else if (exc.illegal || exc.unsupported) begin
         if (exc.ecall) begin
            trap.cause = csr_pkg::CAUSE_ECALL_M;
         end else begin
            trap.cause = csr_pkg::CAUSE_ILLEGAL_INST;
         end
      end else if (exc.load_misaligned) begin
         trap.cause = csr_pkg::CAUSE_LOAD_MISALIGNED;
         trap.tval  = badaddr_q;
      end else if (exc.store_misaligned) begin
         trap.cause = csr_pkg::CAUSE_STORE_MISALIGNED;
         trap.tval  = badaddr_q;
      end
   end

   a_no_trap_in_bubble: assert property (
      @(posedge clk) disable iff (!resetb)
      xb_bubble |-> !initiate_exception
   ) else $error("csr_trap_unit: trap raised for a bubble");

   // Register file state feeding the trap path is always defined out of reset
   a_state_known: assert property (
      @(posedge clk) disable iff (!resetb)
      !$isunknown({mie, csr_illegal})
   ) else $error("csr_trap_unit: mie or csr_illegal unknown");

endmodule

// File: hw/csr_counters.sv
// Machine cycle and retired instruction counters
// 64-bit mcycle and minstret, each writable one 32-bit half at a time
`timescale 1ns/100ps

module csr_counters (
   input  logic              clk,
   input  logic              resetb,
   input  logic              xb_bubble,
   input  csr_pkg::cnt_wr_t  cnt_wr,
   output logic [63:0]       mcycle,
   output logic [63:0]       minstret
);

   // A half write replaces the increment for that cycle
   function automatic logic [63:0] next_count(
      input logic [63:0]    cur,
      input logic           inc,
      input logic           wr_lo,
      input logic           wr_hi,
      input csr_pkg::word_t data
   );
      logic [63:0] nxt;
      if (wr_lo) begin
         nxt = {cur[63:32], data};
      end else if (wr_hi) begin
         nxt = {data, cur[31:0]};
      end else begin
         nxt = cur + {63'd0, inc};
      end
      return nxt;
   endfunction

   always_ff @(posedge clk or negedge resetb) begin
      if (!resetb) begin
         mcycle   <= 64'd0;
         minstret <= 64'd0;
      end else begin
         mcycle   <= next_count(mcycle, 1'b1, cnt_wr.cycle_lo, cnt_wr.cycle_hi,
                                cnt_wr.data);
         // Retired means the XB stage held a real instruction
         minstret <= next_count(minstret, !xb_bubble, cnt_wr.inst_lo, cnt_wr.inst_hi,
                                cnt_wr.data);
      end
   end

   a_one_half: assert property (
      @(posedge clk) disable iff (!resetb)
      !(cnt_wr.cycle_lo && cnt_wr.cycle_hi) && !(cnt_wr.inst_lo && cnt_wr.inst_hi)
   ) else $error("csr_counters: both halves of a counter written in one cycle");

endmodule

// File: hw/csr_op_decode.sv
// CSR request decode
// Turns an opcode and its operands into gated read, write, set and clear strobes
`timescale 1ns/100ps

module csr_op_decode (
   input  logic                 clk,
   input  logic                 resetb,
   input  csr_pkg::csr_req_t    req,
   output csr_pkg::csr_access_t acc
);

   logic uimm_nz;
   logic rd_nz;

   assign uimm_nz = (req.uimm != 5'd0);
   assign rd_nz   = (req.rd != 5'd0);

   always_comb begin
      acc.addr   = req.addr;
      acc.any_op = (req.op != csr_pkg::OP_NONE);

      // Immediate forms use the zero-extended uimm field
      if (req.imm) begin
         acc.operand = {27'd0, req.uimm};
      end else begin
         acc.operand = req.rs1_data;
      end

      // No read side effect with rd = x0, no set or clear with a zero source
      acc.rd_en  = acc.any_op && rd_nz;
      acc.wr_en  = (req.op == csr_pkg::OP_RW);
      acc.set_en = (req.op == csr_pkg::OP_RS) && uimm_nz;
      acc.clr_en = (req.op == csr_pkg::OP_RC) && uimm_nz;
   end

   // Only one kind of modification reaches the register file per cycle
   a_one_modify: assert property (
      @(posedge clk) disable iff (!resetb)
      $onehot0({acc.wr_en, acc.set_en, acc.clr_en})
   ) else $error("csr_op_decode: more than one of write, set and clear active");

endmodule

// File: hw/csr_pkg.sv
// Machine-mode CSR block shared definitions
// CSR addresses, opcode and cause enums, and the structs passed between blocks
package csr_pkg;

   typedef logic [31:0] word_t;
   typedef logic [11:0] csr_addr_t;

   typedef enum logic [1:0] {
      OP_NONE,
      OP_RW,
      OP_RS,
      OP_RC
   } csr_op_e;

   // mcause exception codes
   typedef enum logic [3:0] {
      CAUSE_INST_MISALIGNED  = 4'd0,
      CAUSE_ILLEGAL_INST     = 4'd2,
      CAUSE_LOAD_MISALIGNED  = 4'd4,
      CAUSE_STORE_MISALIGNED = 4'd6,
      CAUSE_ECALL_M          = 4'd11
   } cause_e;

   // Identity CSRs
   localparam csr_addr_t CSR_MVENDORID = 12'hF11;
   localparam csr_addr_t CSR_MARCHID   = 12'hF12;
   localparam csr_addr_t CSR_MIMPID    = 12'hF13;
   localparam csr_addr_t CSR_MHARTID   = 12'hF14;
   // Trap setup and handling
   localparam csr_addr_t CSR_MSTATUS   = 12'h300;
   localparam csr_addr_t CSR_MISA      = 12'h301;
   localparam csr_addr_t CSR_MTVEC     = 12'h305;
   localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
   localparam csr_addr_t CSR_MEPC      = 12'h341;
   localparam csr_addr_t CSR_MCAUSE    = 12'h342;
   localparam csr_addr_t CSR_MTVAL     = 12'h343;
   // Counters
   localparam csr_addr_t CSR_MCYCLE    = 12'hB00;
   localparam csr_addr_t CSR_MINSTRET  = 12'hB02;
   localparam csr_addr_t CSR_MCYCLEH   = 12'hB80;
   localparam csr_addr_t CSR_MINSTRETH = 12'hB82;

   // MXL = 1 (32 bit), I extension
   localparam word_t MISA_VALUE  = 32'h4000_0100;
   localparam word_t MTVEC_RESET = 32'h0000_0004;

   // Upper address bytes of the hard-wired performance monitors
   localparam int NUM_PERF_PREFIXES = 6;
   localparam logic [NUM_PERF_PREFIXES-1:0][7:0] PERF_PREFIXES =
      {8'hB0, 8'hB1, 8'hB8, 8'hB9, 8'h32, 8'h33};

   typedef struct packed {
      csr_op_e   op;
      logic      imm;
      logic [4:0] rd;
      csr_addr_t addr;
      logic [4:0] uimm;
      word_t     rs1_data;
   } csr_req_t;

   typedef struct packed {
      logic      rd_en;
      logic      wr_en;
      logic      set_en;
      logic      clr_en;
      logic      any_op;
      csr_addr_t addr;
      word_t     operand;
   } csr_access_t;

   typedef struct packed {
      logic unsupported;
      logic illegal;
      logic ecall;
      logic inst_misaligned;
      logic load_misaligned;
      logic store_misaligned;
   } exc_flags_t;

   typedef struct packed {
      logic   take;
      cause_e cause;
      word_t  tval;
   } trap_info_t;

   typedef struct packed {
      logic  cycle_lo;
      logic  cycle_hi;
      logic  inst_lo;
      logic  inst_hi;
      word_t data;
   } cnt_wr_t;

endpackage
